/* Bender.yml */
package:
  name: axi_ram_model

sources:
  - include_dirs:
      - include
    files:
      - design/rammodel_pkg.sv
      - design/rammodel_req_if.sv
      - design/rammodel_fifo.sv
      - design/burst_addr_gen.sv
      - design/rammodel_backend.sv
      - design/rammodel_frontend.sv
      - design/axi_ram_model.sv
      - target: test
        files:
          - test/axi_ram_model_tb.sv

/* design/axi_ram_model.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

module axi_ram_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`ID_WIDTH-1:0]     arid,
    input  logic [`ADDR_WIDTH-1:0]   araddr,
    input  logic [7:0]               arlen,
    input  logic [2:0]               arsize,
    input  logic [1:0]               arburst,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`ID_WIDTH-1:0]     awid,
    input  logic [`ADDR_WIDTH-1:0]   awaddr,
    input  logic [7:0]               awlen,
    input  logic [2:0]               awsize,
    input  logic [1:0]               awburst,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`DATA_WIDTH-1:0]   wdata,
    input  logic [`DATA_WIDTH/8-1:0] wstrb,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [`ID_WIDTH-1:0]     bid,
    output logic [1:0]               bresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`ID_WIDTH-1:0]     rid,
    output logic [`DATA_WIDTH-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rlast
);

    rammodel_req_if req_if ();

    rammodel_frontend i_frontend (
        .clk(clk), .rst(rst),
        .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
        .arlen(arlen), .arsize(arsize), .arburst(arburst),
        .awvalid(awvalid), .awready(awready), .awid(awid), .awaddr(awaddr),
        .awlen(awlen), .awsize(awsize), .awburst(awburst),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
        .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
        .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
        .rresp(rresp), .rlast(rlast),
        .req(req_if.front)
    );

    rammodel_backend i_backend (
        .clk(clk),
        .rst(rst),
        .req(req_if.back)
    );

endmodule

/* design/burst_addr_gen.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

module burst_addr_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  rammodel_pkg::axi_req_t start,
    input  logic                   step,
    output logic [`ADDR_WIDTH-1:0] addr,
    output logic                   last
);
    import rammodel_pkg::*;

    localparam int AW = `ADDR_WIDTH;

    logic [AW-1:0] addr_q;
    logic [AW-1:0] next_addr;
    logic [AW-1:0] beat_bytes;
    logic [AW-1:0] wrap_mask;
    logic [7:0]    len_q;
    logic [7:0]    beat_cnt;
    logic [2:0]    size_q;
    burst_e        burst_q;

    assign beat_bytes = AW'(1) << size_q;
    assign wrap_mask  = ((AW'(len_q) + 1'b1) << size_q) - 1'b1; // Window of (len+1) beats

    always_comb begin
        case (burst_q)
            FIXED:   next_addr = addr_q;
            WRAP:    next_addr = (addr_q & ~wrap_mask) | ((addr_q + beat_bytes) & wrap_mask);
            default: next_addr = addr_q + beat_bytes;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
            len_q    <= '0;
        end else if (load) begin
            beat_cnt <= '0;
            len_q    <= start.len;
        end else if (step) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q  <= start.addr;
            size_q  <= start.size;
            burst_q <= start.burst;
        end else if (step) begin
            addr_q <= next_addr;
        end
    end

    assign addr = addr_q;
    assign last = (beat_cnt == len_q);

endmodule

/* design/rammodel_backend.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

module rammodel_backend (
    input  logic           clk,
    input  logic           rst,
    rammodel_req_if.back   req
);
    import rammodel_pkg::*;

    localparam int AW       = `ADDR_WIDTH;
    localparam int DW       = `DATA_WIDTH;
    localparam int ID_W     = `ID_WIDTH;
    localparam int STRB_W   = DW / 8;
    localparam int WORD_LSB = $clog2(STRB_W);
    localparam int IDX_W    = $clog2(`MEM_WORDS);

    logic [DW-1:0] mem [`MEM_WORDS];

    // Queue heads and status
    axi_req_t ar_head;
    axi_req_t aw_head;
    w_beat_t  w_head;
    r_beat_t  r_in;
    logic     ar_empty;
    logic     aw_empty;
    logic     w_empty;
    logic     w_full;
    logic     b_empty;
    logic     r_empty;
    logic     r_full;
    logic     ar_pop;
    logic     aw_pop;
    logic     w_pop;
    logic     r_push;

    // Engines
    logic             rd_busy;
    logic             rd_load;
    logic             rd_step;
    logic             rd_last;
    logic [AW-1:0]    rd_addr;
    logic [IDX_W-1:0] rd_word;
    logic             wr_busy;
    logic             wr_load;
    logic             wr_step;
    logic             wr_last;
    logic [AW-1:0]    wr_addr;
    logic [IDX_W-1:0] wr_word;
    logic             b_push_q;
    logic [ID_W-1:0]  b_id_q;

    rammodel_fifo #(.WIDTH($bits(axi_req_t)), .DEPTH(`MAX_R_INFLIGHT)) i_ar_fifo (
        .clk(clk), .rst(rst),
        .push(req.ar_push), .push_data(req.ar),
        .pop(ar_pop), .pop_data(ar_head),
        .empty(ar_empty), .full()
    );

    rammodel_fifo #(.WIDTH($bits(axi_req_t)), .DEPTH(`MAX_W_INFLIGHT)) i_aw_fifo (
        .clk(clk), .rst(rst),
        .push(req.aw_push), .push_data(req.aw),
        .pop(aw_pop), .pop_data(aw_head),
        .empty(aw_empty), .full()
    );

    rammodel_fifo #(.WIDTH($bits(w_beat_t)), .DEPTH(`W_FIFO_DEPTH)) i_w_fifo (
        .clk(clk), .rst(rst),
        .push(req.w_push), .push_data(req.w),
        .pop(w_pop), .pop_data(w_head),
        .empty(w_empty), .full(w_full)
    );

    rammodel_fifo #(.WIDTH(ID_W), .DEPTH(`MAX_W_INFLIGHT)) i_b_fifo (
        .clk(clk), .rst(rst),
        .push(b_push_q), .push_data(b_id_q),
        .pop(req.b_pop), .pop_data(req.b_id),
        .empty(b_empty), .full()
    );

    rammodel_fifo #(.WIDTH($bits(r_beat_t)), .DEPTH(`R_FIFO_DEPTH)) i_r_fifo (
        .clk(clk), .rst(rst),
        .push(r_push), .push_data(r_in),
        .pop(req.r_pop), .pop_data(req.r),
        .empty(r_empty), .full(r_full)
    );

    assign req.w_space = !w_full;
    assign req.b_valid = !b_empty;
    assign req.r_valid = !r_empty;

    // Read engine, AR stays at the head until its last beat
    burst_addr_gen i_rd_gen (
        .clk(clk), .rst(rst),
        .load(rd_load), .start(ar_head), .step(rd_step),
        .addr(rd_addr), .last(rd_last)
    );

    assign rd_load = !rd_busy && !ar_empty;
    assign rd_step = rd_busy && !r_full;
    assign ar_pop  = rd_step && rd_last;
    assign r_push  = rd_step;
    assign rd_word = rd_addr[WORD_LSB +: IDX_W];
    assign r_in    = '{id: ar_head.id, data: mem[rd_word], last: rd_last};

    always_ff @(posedge clk) begin
        if (rst) rd_busy <= 1'b0;
        else if (rd_load) rd_busy <= 1'b1;
        else if (ar_pop) rd_busy <= 1'b0;
    end

    // Write engine pairs the head AW with queued W beats
    burst_addr_gen i_wr_gen (
        .clk(clk), .rst(rst),
        .load(wr_load), .start(aw_head), .step(wr_step),
        .addr(wr_addr), .last(wr_last)
    );

    assign wr_load = !wr_busy && !aw_empty;
    assign wr_step = wr_busy && !w_empty;
    assign w_pop   = wr_step;
    assign aw_pop  = wr_step && wr_last;
    assign wr_word = wr_addr[WORD_LSB +: IDX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_busy  <= 1'b0;
            b_push_q <= 1'b0;
        end else begin
            b_push_q <= aw_pop; // Response enters B queue a cycle after the last write
            if (wr_load) wr_busy <= 1'b1;
            else if (aw_pop) wr_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_pop) b_id_q <= aw_head.id;
    end

    always_ff @(posedge clk) begin
        if (wr_step) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w_head.strb[i]) mem[wr_word][8*i +: 8] <= w_head.data[8*i +: 8];
            end
        end
    end

endmodule

/* design/rammodel_fifo.sv */
`timescale 1ns/1ns

module rammodel_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) slots[wr_ptr] <= push_data;
    end

    assign pop_data = slots[rd_ptr]; // Head visible without a pop
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

endmodule

/* design/rammodel_frontend.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

module rammodel_frontend (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`ID_WIDTH-1:0]     arid,
    input  logic [`ADDR_WIDTH-1:0]   araddr,
    input  logic [7:0]               arlen,
    input  logic [2:0]               arsize,
    input  logic [1:0]               arburst,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`ID_WIDTH-1:0]     awid,
    input  logic [`ADDR_WIDTH-1:0]   awaddr,
    input  logic [7:0]               awlen,
    input  logic [2:0]               awsize,
    input  logic [1:0]               awburst,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`DATA_WIDTH-1:0]   wdata,
    input  logic [`DATA_WIDTH/8-1:0] wstrb,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [`ID_WIDTH-1:0]     bid,
    output logic [1:0]               bresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`ID_WIDTH-1:0]     rid,
    output logic [`DATA_WIDTH-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rlast,
    rammodel_req_if.front            req
);
    import rammodel_pkg::*;

    localparam int MAX_R = `MAX_R_INFLIGHT;
    localparam int MAX_W = `MAX_W_INFLIGHT;
    localparam int RC_W  = $clog2(MAX_R + 1);
    localparam int WC_W  = $clog2(MAX_W + 1);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic            ready_en;
    logic [RC_W-1:0] rd_cnt;
    logic [WC_W-1:0] wr_cnt;
    logic            ar_hs;
    logic            aw_hs;
    logic            r_done;
    logic            b_hs;

    assign ar_hs  = arvalid && arready;
    assign aw_hs  = awvalid && awready;
    assign r_done = rvalid && rready && rlast; // Burst leaves the read count
    assign b_hs   = bvalid && bready;

    assign arready = ready_en && (rd_cnt < MAX_R);
    assign awready = ready_en && (wr_cnt < MAX_W);
    assign wready  = ready_en && req.w_space;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en    <= 1'b0;
            rd_cnt      <= '0;
            wr_cnt      <= '0;
            req.ar_push <= 1'b0;
            req.aw_push <= 1'b0;
        end else begin
            ready_en    <= 1'b1;
            req.ar_push <= ar_hs;
            req.aw_push <= aw_hs;
            if (ar_hs && !r_done) rd_cnt <= rd_cnt + 1'b1;
            else if (!ar_hs && r_done) rd_cnt <= rd_cnt - 1'b1;
            if (aw_hs && !b_hs) wr_cnt <= wr_cnt + 1'b1;
            else if (!aw_hs && b_hs) wr_cnt <= wr_cnt - 1'b1;
        end
    end

    // Request payloads, valid with the registered push
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            req.ar <= '{id: arid, addr: araddr, len: arlen, size: arsize,
                        burst: burst_e'(arburst)};
        end
        if (aw_hs) begin
            req.aw <= '{id: awid, addr: awaddr, len: awlen, size: awsize,
                        burst: burst_e'(awburst)};
        end
    end

    // W beats go straight into the queue
    assign req.w_push = wvalid && wready;
    assign req.w      = '{data: wdata, strb: wstrb, last: wlast};

    assign req.b_pop = b_hs;
    assign req.r_pop = rvalid && rready;

    assign bvalid = req.b_valid;
    assign bid    = req.b_id;
    assign bresp  = RESP_OKAY;
    assign rvalid = req.r_valid;
    assign rid    = req.r.id;
    assign rdata  = req.r.data;
    assign rlast  = req.r.last;
    assign rresp  = RESP_OKAY;

endmodule

/* design/rammodel_pkg.sv */
`include "rammodel_config.svh"

package rammodel_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // One AR or AW burst request
    typedef struct packed {
        logic [`ID_WIDTH-1:0]   id;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [7:0]             len;  // Beats minus one
        logic [2:0]             size; // Log2 of beat bytes
        burst_e                 burst;
    } axi_req_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]   data;
        logic [`DATA_WIDTH/8-1:0] strb;
        logic                     last;
    } w_beat_t;

    typedef struct packed {
        logic [`ID_WIDTH-1:0]   id;
        logic [`DATA_WIDTH-1:0] data;
        logic                   last;
    } r_beat_t;

endpackage

/* design/rammodel_req_if.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

interface rammodel_req_if;
    import rammodel_pkg::*;

    // Request side, one-cycle pulses with payload
    logic     ar_push;
    axi_req_t ar;
    logic     aw_push;
    axi_req_t aw;
    logic     w_push;
    w_beat_t  w;
    logic     b_pop;
    logic     r_pop;

    // Queue status and fronts
    logic                 w_space;
    logic                 b_valid;
    logic [`ID_WIDTH-1:0] b_id;
    logic                 r_valid;
    r_beat_t              r;

    modport front (
        output ar_push, ar,
        output aw_push, aw,
        output w_push, w,
        output b_pop, r_pop,
        input  w_space,
        input  b_valid, b_id,
        input  r_valid, r
    );

    modport back (
        input  ar_push, ar,
        input  aw_push, aw,
        input  w_push, w,
        input  b_pop, r_pop,
        output w_space,
        output b_valid, b_id,
        output r_valid, r
    );

endinterface

/* include/rammodel_config.svh */
`ifndef RAMMODEL_CONFIG_SVH
`define RAMMODEL_CONFIG_SVH

// Bus geometry
`define ADDR_WIDTH 16
`define DATA_WIDTH 64
`define ID_WIDTH 4

// Storage size in DATA_WIDTH words
`define MEM_WORDS 1024

`define MAX_R_INFLIGHT 8 // Also the AR queue depth
`define MAX_W_INFLIGHT 8 // Also the AW and B queue depth
`define R_FIFO_DEPTH 16
`define W_FIFO_DEPTH 16

`endif

/* project.f */
+incdir+include
design/rammodel_pkg.sv
design/rammodel_req_if.sv
design/rammodel_fifo.sv
design/burst_addr_gen.sv
design/rammodel_backend.sv
design/rammodel_frontend.sv
design/axi_ram_model.sv
test/axi_ram_model_tb.sv

/* test/axi_ram_model_tb.sv */
`timescale 1ns/1ns

`include "rammodel_config.svh"

module axi_ram_model_tb;

    localparam int NB = `DATA_WIDTH / 8;
    localparam logic [1:0] B_FIXED = 2'b00;
    localparam logic [1:0] B_INCR  = 2'b01;
    localparam logic [1:0] B_WRAP  = 2'b10;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 arvalid = 1'b0;
    logic                 arready;
    logic [`ID_WIDTH-1:0] arid = '0;
    logic [15:0]          araddr = '0;
    logic [7:0]           arlen = '0;
    logic [2:0]           arsize = '0;
    logic [1:0]           arburst = '0;
    logic                 awvalid = 1'b0;
    logic                 awready;
    logic [`ID_WIDTH-1:0] awid = '0;
    logic [15:0]          awaddr = '0;
    logic [7:0]           awlen = '0;
    logic [2:0]           awsize = '0;
    logic [1:0]           awburst = '0;
    logic                 wvalid = 1'b0;
    logic                 wready;
    logic [`DATA_WIDTH-1:0] wdata = '0;
    logic [NB-1:0]        wstrb = '0;
    logic                 wlast = 1'b0;
    logic                 bvalid;
    logic                 bready = 1'b1;
    logic [`ID_WIDTH-1:0] bid;
    logic [1:0]           bresp;
    logic                 rvalid;
    logic                 rready = 1'b1;
    logic [`ID_WIDTH-1:0] rid;
    logic [`DATA_WIDTH-1:0] rdata;
    logic [1:0]           rresp;
    logic                 rlast;

    logic [7:0]           shadow [`MEM_WORDS*NB]; // Byte image of the expected memory
    logic [`ID_WIDTH-1:0] exp_rid [$];
    logic [`DATA_WIDTH-1:0] exp_rdata [$];
    logic                 exp_rlast [$];
    logic [`ID_WIDTH-1:0] exp_bid [$];
    int                   err_cnt = 0;
    int                   timeout_cnt = 0;

    axi_ram_model i_axi_ram_model (.*);

    always #5 clk = ~clk;

    // Responses must follow request order
    always @(posedge clk) begin
        if (!rst && rvalid && rready) begin
            assert (exp_rid.size() > 0) else begin
                err_cnt++;
                $display("ERROR at %0t: unexpected R beat with id %h", $time, rid);
            end
            if (exp_rid.size() > 0) begin
                assert (rid === exp_rid[0] && rdata === exp_rdata[0] &&
                        rlast === exp_rlast[0] && rresp === 2'b00) else begin
                    err_cnt++;
                    $display("ERROR at %0t: R id %h data %h last %b resp %0d", $time,
                             rid, rdata, rlast, rresp);
                    $display("ERROR at %0t: expected id %h data %h last %b", $time,
                             exp_rid[0], exp_rdata[0], exp_rlast[0]);
                end
                void'(exp_rid.pop_front());
                void'(exp_rdata.pop_front());
                void'(exp_rlast.pop_front());
            end
        end
        if (!rst && bvalid && bready) begin
            assert (exp_bid.size() > 0 && bid === exp_bid[0] && bresp === 2'b00) else begin
                err_cnt++;
                $display("ERROR at %0t: B id %h resp %0d not expected", $time, bid, bresp);
            end
            if (exp_bid.size() > 0) void'(exp_bid.pop_front());
        end
    end

    function automatic logic [15:0] beat_addr(input logic [15:0] addr, input logic [7:0] len,
                                              input logic [2:0] size, input logic [1:0] burst,
                                              input int beat);
        int bytes;
        int window;
        int a;
        bytes  = 1 << size;
        window = bytes * (len + 1);
        a      = addr;
        case (burst)
            B_FIXED: return addr;
            B_WRAP:  return 16'((a / window) * window + (a + beat * bytes) % window);
            default: return 16'(a + beat * bytes);
        endcase
    endfunction

    function automatic logic [NB-1:0] lane_mask(input logic [15:0] a, input logic [2:0] size);
        logic [NB-1:0] m;
        m = NB'((32'h1 << (1 << size)) - 1);
        return m << (a % NB);
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] word_at(input logic [15:0] a);
        logic [`DATA_WIDTH-1:0] w;
        int base;
        base = ((a / NB) % `MEM_WORDS) * NB;
        for (int j = 0; j < NB; j++) w[8*j +: 8] = shadow[base + j];
        return w;
    endfunction

    function automatic logic ready_of(input string ch);
        return (ch == "AR") ? arready : (ch == "AW") ? awready : wready;
    endfunction

    // Returns 1 ns after the edge that completed the handshake
    task automatic wait_ready(input string ch);
        int cyc;
        cyc = 0;
        @(posedge clk);
        while (!ready_of(ch) && cyc < 1000) begin
            @(posedge clk);
            cyc++;
        end
        assert (ready_of(ch)) else begin
            timeout_cnt++;
            $display("Timeout: no %s handshake within 1000 cycles at %0t", ch, $time);
        end
        #1;
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while ((exp_rid.size() > 0 || exp_bid.size() > 0) && cyc < 1000) begin
            @(negedge clk);
            cyc++;
        end
        assert (exp_rid.size() == 0 && exp_bid.size() == 0) else begin
            timeout_cnt++;
            $display("Timeout: %0d R beats and %0d B responses never arrived",
                     exp_rid.size(), exp_bid.size());
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic [2:0] size,
                               input logic [1:0] burst, input bit rand_strb);
        logic [15:0]   a;
        logic [NB-1:0] strb;
        exp_bid.push_back(id);
        awvalid = 1'b1;
        {awid, awaddr, awlen, awsize, awburst} = {id, addr, len, size, burst};
        wait_ready("AW");
        awvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            a    = beat_addr(addr, len, size, burst, i);
            strb = rand_strb ? lane_mask(a, size) & NB'($urandom) : lane_mask(a, size);
            wdata = {$urandom, $urandom};
            for (int j = 0; j < NB; j++) begin
                if (strb[j]) shadow[((a / NB) % `MEM_WORDS) * NB + j] = wdata[8*j +: 8];
            end
            wvalid = 1'b1;
            wstrb  = strb;
            wlast  = (i == len);
            wait_ready("W");
        end
        wvalid = 1'b0;
    endtask

    task automatic expect_read(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic [2:0] size,
                               input logic [1:0] burst);
        for (int i = 0; i <= len; i++) begin
            exp_rid.push_back(id);
            exp_rdata.push_back(word_at(beat_addr(addr, len, size, burst, i)));
            exp_rlast.push_back(i == len);
        end
        arvalid = 1'b1;
        {arid, araddr, arlen, arsize, arburst} = {id, addr, len, size, burst};
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                              input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst);
        expect_read(id, addr, len, size, burst);
        wait_ready("AR");
        arvalid = 1'b0;
    endtask

    task automatic check_reset();
        int cyc;
        cyc = 0;
        assert (!bvalid && !rvalid) else begin
            err_cnt++;
            $display("ERROR at %0t: bvalid or rvalid high after reset", $time);
        end
        while (!(arready && awready && wready) && cyc < 5) begin
            @(posedge clk);
            cyc++;
        end
        assert (arready && awready && wready) else begin
            err_cnt++;
            $display("ERROR at %0t: ready signals still low after reset", $time);
        end
        #1;
    endtask

    task automatic read_backpressure();
        write_burst(4'h9, 16'h600, 8'd31, 3'd3, B_INCR, 1'b0);
        wait_idle();
        rready = 1'b0;
        for (int i = 0; i < `MAX_R_INFLIGHT; i++) begin
            read_burst(4'(i), 16'h600 + 16'(i * 32), 8'd3, 3'd3, B_INCR);
        end
        expect_read(4'hf, 16'h600, 8'd3, 3'd3, B_INCR); // One over the limit
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            assert (!arready) else begin
                err_cnt++;
                $display("ERROR at %0t: AR accepted beyond the outstanding limit", $time);
            end
        end
        #1;
        rready = 1'b1;
        wait_ready("AR");
        arvalid = 1'b0;
        wait_idle();
    endtask

    task automatic mixed_order();
        bready = 1'b0;
        write_burst(4'ha, 16'h700, 8'd1, 3'd3, B_INCR, 1'b1);
        read_burst(4'hb, 16'h600, 8'd1, 3'd3, B_INCR);
        write_burst(4'hc, 16'h740, 8'd1, 3'd3, B_WRAP, 1'b0);
        read_burst(4'hd, 16'h620, 8'd3, 3'd3, B_INCR);
        write_burst(4'he, 16'h780, 8'd0, 3'd3, B_FIXED, 1'b0);
        repeat (30) @(posedge clk);
        assert (bvalid) else begin
            err_cnt++;
            $display("ERROR at %0t: no B response pending while bready low", $time);
        end
        #1;
        bready = 1'b1;
        wait_idle();
    endtask

    initial begin
        void'($urandom(50));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset();
        write_burst(4'h1, 16'h100, 8'd7, 3'd3, B_INCR, 1'b0);
        wait_idle();
        read_burst(4'h2, 16'h100, 8'd7, 3'd3, B_INCR);
        wait_idle();
        write_burst(4'h3, 16'h100, 8'd7, 3'd3, B_INCR, 1'b1); // Random strobes
        wait_idle();
        read_burst(4'h4, 16'h100, 8'd7, 3'd3, B_INCR);
        wait_idle();
        write_burst(4'h5, 16'h200, 8'd3, 3'd3, B_FIXED, 1'b0);
        write_burst(4'h6, 16'h318, 8'd3, 3'd3, B_WRAP, 1'b0);
        write_burst(4'h7, 16'h402, 8'd5, 3'd1, B_INCR, 1'b0);
        write_burst(4'h8, 16'h50c, 8'd7, 3'd2, B_WRAP, 1'b1);
        wait_idle();
        read_burst(4'h5, 16'h200, 8'd3, 3'd3, B_FIXED);
        read_burst(4'h6, 16'h318, 8'd3, 3'd3, B_WRAP);
        read_burst(4'h7, 16'h402, 8'd5, 3'd1, B_INCR);
        read_burst(4'h8, 16'h50c, 8'd7, 3'd2, B_WRAP);
        read_burst(4'h6, 16'h300, 8'd3, 3'd3, B_INCR); // Wrap windows in address order
        read_burst(4'h8, 16'h500, 8'd3, 3'd3, B_INCR);
        wait_idle();
        read_backpressure();
        mixed_order();
        $display("Errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
